//--- hw/alu_isa_pkg.sv
/*
 * Instruction set definitions for the execution stage.
 * Holds the datapath and register address widths, the pipeline
 * latencies and the 5-bit opcode encoding.
 */

`default_nettype none

package alu_isa_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 8;
    localparam int op_width = 5;

    // Issue to result, including the merge register
    localparam int exec_latency = 4;
    // Issue to the output of either lane
    localparam int lane_latency = 3;

    // Codes 4, 5 and 18 are reserved and decode like a NOP
    typedef enum logic [op_width-1:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_mul  = 5'd3,
        op_ldc  = 5'd6,
        op_ldr  = 5'd7,
        op_bgt  = 5'd8,
        op_ble  = 5'd9,
        op_beq  = 5'd10,
        op_bne  = 5'd11,
        op_stop = 5'd12,
        op_and  = 5'd13,
        op_or   = 5'd14,
        op_not  = 5'd15,
        op_satp = 5'd16,
        op_satn = 5'd17
    } alu_op_e;

endpackage

`default_nettype wire

//--- hw/alu_stream_pkg.sv
/*
 * Stream types exchanged between the execution stage blocks.
 * Contains the issue bus, the per-lane result and the final
 * flagged result returned to writeback.
 */

`default_nettype none

package alu_stream_pkg;

    import alu_isa_pkg::*;

    // One operation per clock from the issue logic
    typedef struct packed {
        logic                      valid;
        alu_op_e                   op;
        logic [data_width-1:0]     a;
        logic [data_width-1:0]     b;
        logic [reg_addr_width-1:0] dest;
    } alu_issue_t;

    // Halt is only ever set by the STOP marker, with valid low
    typedef struct packed {
        logic                      valid;
        logic                      halt;
        logic [data_width-1:0]     data;
        logic [reg_addr_width-1:0] dest;
    } lane_result_t;

    typedef struct packed {
        logic                      valid;
        logic [data_width-1:0]     data;
        logic [reg_addr_width-1:0] dest;
        logic                      zero;
        logic                      negative;
    } alu_result_t;

endpackage

`default_nettype wire

//--- hw/stage_delay.sv
/*
 * Shift chain of lane result registers.
 * Aligns units of different depth to a common lane latency.
 * A depth of zero degenerates to a plain connection.
 */

`timescale 1ns/1ps
`default_nettype none

module stage_delay import alu_stream_pkg::*; #(
    parameter int stages = 1
) (
    input  wire          clock,
    input  wire          rst_n,
    input  wire lane_result_t in,
    output lane_result_t out
);

    if (stages == 0) begin : g_bypass
        assign out = in;
    end else begin : g_chain
        lane_result_t pipe [stages];

        // Payload shifts freely, only the control bits are cleared
        always_ff @(posedge clock) begin
            pipe[0] <= in;
            for (int i = 1; i < stages; i++) begin
                pipe[i] <= pipe[i-1];
            end
            if (!rst_n) begin
                for (int i = 0; i < stages; i++) begin
                    pipe[i].valid <= 1'b0;
                    pipe[i].halt <= 1'b0;
                end
            end
        end

        assign out = pipe[stages-1];
    end

endmodule

`default_nettype wire

//--- hw/arith_lane.sv
/*
 * Arithmetic lane of the execution stage.
 * Add, subtract and the signed compares take one register stage,
 * multiply takes two. Both paths are aligned to lane_latency.
 */

`timescale 1ns/1ps
`default_nettype none

module arith_lane import alu_isa_pkg::*, alu_stream_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire alu_issue_t issue,
    output lane_result_t    lane_out
);

    localparam int half = data_width / 2;

    logic                  a_gt_b;
    logic                  a_eq_b;
    logic                  short_hit;
    logic [data_width-1:0] short_data;
    lane_result_t          short_q;
    lane_result_t          short_aligned;

    logic                      mul_valid_s1;
    logic [reg_addr_width-1:0] mul_dest_s1;
    logic [data_width-1:0]     pp_lo_next;
    logic [half-1:0]           pp_hi_next;
    logic [data_width-1:0]     pp_lo_q;
    logic [half-1:0]           pp_hi_q;
    lane_result_t              mul_q;
    lane_result_t              mul_aligned;

    assign a_gt_b = $signed(issue.a) > $signed(issue.b);
    assign a_eq_b = issue.a == issue.b;

    always_comb begin
        short_hit = 1'b1;
        short_data = '0;
        case (issue.op)
            op_add: short_data = issue.a + issue.b;
            op_sub: short_data = issue.a - issue.b;
            op_bgt: short_data = {{(data_width-1){1'b0}}, a_gt_b};
            op_ble: short_data = {{(data_width-1){1'b0}}, !a_gt_b};
            op_beq: short_data = {{(data_width-1){1'b0}}, a_eq_b};
            op_bne: short_data = {{(data_width-1){1'b0}}, !a_eq_b};
            default: short_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        short_q.data <= short_data;
        short_q.dest <= issue.dest;
        short_q.halt <= 1'b0;
        if (!rst_n) begin
            short_q.valid <= 1'b0;
        end else begin
            short_q.valid <= issue.valid && short_hit;
        end
    end

    stage_delay #(
        .stages(lane_latency - 1)
    ) u_short_delay (
        .clock(clock),
        .rst_n(rst_n),
        .in(short_q),
        .out(short_aligned)
    );

    // The low word of a two's complement product does not depend on
    // signedness, so b is split into halves and the partial products
    // are summed in the second stage
    assign pp_lo_next = issue.a * {{half{1'b0}}, issue.b[half-1:0]};
    assign pp_hi_next = issue.a[half-1:0] * issue.b[data_width-1:half];

    always_ff @(posedge clock) begin
        pp_lo_q <= pp_lo_next;
        pp_hi_q <= pp_hi_next;
        mul_dest_s1 <= issue.dest;
        mul_q.data <= pp_lo_q + {pp_hi_q, {half{1'b0}}};
        mul_q.dest <= mul_dest_s1;
        mul_q.halt <= 1'b0;
        if (!rst_n) begin
            mul_valid_s1 <= 1'b0;
            mul_q.valid <= 1'b0;
        end else begin
            mul_valid_s1 <= issue.valid && (issue.op == op_mul);
            mul_q.valid <= mul_valid_s1;
        end
    end

    stage_delay #(
        .stages(lane_latency - 2)
    ) u_mul_delay (
        .clock(clock),
        .rst_n(rst_n),
        .in(mul_q),
        .out(mul_aligned)
    );

    // Equal latency on both paths keeps their valid bits apart
    assign lane_out = short_aligned.valid ? short_aligned : mul_aligned;

endmodule

`default_nettype wire

//--- hw/logic_lane.sv
/*
 * Logic lane of the execution stage.
 * Bitwise operations, signed saturation, register and constant
 * loads, and the STOP marker that halts writeback.
 */

`timescale 1ns/1ps
`default_nettype none

module logic_lane import alu_isa_pkg::*, alu_stream_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire alu_issue_t issue,
    output lane_result_t    lane_out
);

    logic                  a_gt_b;
    logic                  logic_hit;
    logic                  stop_hit;
    logic [data_width-1:0] logic_data;
    lane_result_t          logic_q;

    assign a_gt_b = $signed(issue.a) > $signed(issue.b);

    always_comb begin
        logic_hit = 1'b1;
        stop_hit = 1'b0;
        logic_data = '0;
        case (issue.op)
            op_and: logic_data = issue.a & issue.b;
            op_or:  logic_data = issue.a | issue.b;
            op_not: logic_data = ~issue.a;
            // Clamp a to the upper limit b
            op_satp: logic_data = a_gt_b ? issue.b : issue.a;
            // Clamp a to the lower limit b
            op_satn: logic_data = a_gt_b ? issue.a : issue.b;
            op_ldr: logic_data = issue.a;
            // The constant arrives as the immediate on operand b
            op_ldc: logic_data = issue.b;
            op_stop: begin
                logic_hit = 1'b0;
                stop_hit = 1'b1;
            end
            default: logic_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        logic_q.data <= logic_data;
        logic_q.dest <= issue.dest;
        if (!rst_n) begin
            logic_q.valid <= 1'b0;
            logic_q.halt <= 1'b0;
        end else begin
            logic_q.valid <= issue.valid && logic_hit;
            logic_q.halt <= issue.valid && stop_hit;
        end
    end

    stage_delay #(
        .stages(lane_latency - 1)
    ) u_logic_delay (
        .clock(clock),
        .rst_n(rst_n),
        .in(logic_q),
        .out(lane_out)
    );

endmodule

`default_nettype wire

//--- hw/result_merge.sv
/*
 * Result stage of the execution unit.
 * Registers the valid lane output with its zero and negative
 * flags and holds the sticky halt raised by a STOP.
 */

`timescale 1ns/1ps
`default_nettype none

module result_merge import alu_isa_pkg::*, alu_stream_pkg::*; (
    input  wire               clock,
    input  wire               rst_n,
    input  wire lane_result_t arith_in,
    input  wire lane_result_t logic_in,
    output alu_result_t       result,
    output logic              halted
);

    lane_result_t sel;

    // At most one lane is valid in any cycle
    assign sel = arith_in.valid ? arith_in : logic_in;

    always_ff @(posedge clock) begin
        result.data <= sel.data;
        result.dest <= sel.dest;
        result.zero <= sel.data == '0;
        result.negative <= sel.data[data_width-1];
        if (!rst_n) begin
            result.valid <= 1'b0;
            halted <= 1'b0;
        end else begin
            // Nothing is written back once the STOP slot is reached
            result.valid <= (arith_in.valid || logic_in.valid)
                            && !halted && !logic_in.halt;
            halted <= halted || logic_in.halt;
        end
    end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
/*
 * Top level of the execution stage.
 * Feeds each issue to the arithmetic and logic lanes and joins
 * their outputs in the result stage.
 */

`timescale 1ns/1ps
`default_nettype none

module exec_unit import alu_stream_pkg::*; (
    input  wire             clock,
    input  wire             rst_n,
    input  wire alu_issue_t issue,
    output alu_result_t     result,
    output logic            halted
);

    lane_result_t arith_lane_out;
    lane_result_t logic_lane_out;

    arith_lane u_arith_lane (
        .clock(clock),
        .rst_n(rst_n),
        .issue(issue),
        .lane_out(arith_lane_out)
    );

    logic_lane u_logic_lane (
        .clock(clock),
        .rst_n(rst_n),
        .issue(issue),
        .lane_out(logic_lane_out)
    );

    result_merge u_result_merge (
        .clock(clock),
        .rst_n(rst_n),
        .arith_in(arith_lane_out),
        .logic_in(logic_lane_out),
        .result(result),
        .halted(halted)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
/*
 * Clock and reset source for the execution stage testbench.
 * Runs a 40 ns clock and holds rst_n low for the first three
 * rising edges.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    localparam int period_ns = 40;
    localparam int reset_cycles = 3;

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // Released on a rising edge like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_exec_unit.sv
/*
 * Testbench for the execution stage.
 * Drives random issues from a fixed seed, predicts every result
 * with a behavioral model, checks results, flags and the halt
 * output each cycle, and guards the run with a watchdog.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit import alu_isa_pkg::*, alu_stream_pkg::*; ();

    localparam int period_ns = 40;
    localparam int reset_cycles = 3;
    localparam int num_ops = 400;
    localparam int tail_cycles = 20;
    localparam int timeout_ns = (reset_cycles + num_ops + 40) * period_ns + 2000;

    // Predicted output slot, with a marker for the STOP position
    typedef struct packed {
        logic        stop;
        alu_result_t res;
    } expect_t;

    logic        clock;
    logic        rst_n;
    alu_issue_t  issue;
    alu_result_t result;
    logic        halted;

    integer      seed = 91;
    expect_t     expect_q[$];
    logic        model_halted = 1'b0;
    int          error_count = 0;
    int          result_count = 0;

    tb_clock_gen u_clock_gen (
        .clock(clock),
        .rst_n(rst_n)
    );

    exec_unit u_exec_unit (
        .clock(clock),
        .rst_n(rst_n),
        .issue(issue),
        .result(result),
        .halted(halted)
    );

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("FAILED %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        error_count++;
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    // Corner values a quarter of the time and plain random words otherwise
    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[3:0])
            4'd0: return 32'h0000_0000;
            4'd1: return 32'h7fff_ffff;
            4'd2: return 32'h8000_0000;
            4'd3: return 32'hffff_ffff;
            default: return $random(seed);
        endcase
    endfunction

    function automatic alu_issue_t random_issue(input bit no_stop);
        alu_issue_t x;
        int unsigned pick;
        logic [4:0] code;
        pick = $unsigned($random(seed)) % 100;
        x.valid = pick < 80;
        pick = $unsigned($random(seed)) % 19;
        code = pick[4:0];
        if (no_stop && code == 5'd12) begin
            code = 5'd0;
        end
        x.op = alu_op_e'(code);
        x.a = pick_operand();
        pick = $unsigned($random(seed)) % 4;
        x.b = (pick == 0) ? x.a : pick_operand();
        x.dest = reg_addr_width'($random(seed));
        return x;
    endfunction

    function automatic expect_t expected_result(input alu_issue_t x);
        expect_t e;
        logic signed [63:0] product;
        logic hit;
        e = '0;
        hit = 1'b1;
        product = $signed(x.a) * $signed(x.b);
        case (x.op)
            op_add:  e.res.data = x.a + x.b;
            op_sub:  e.res.data = x.a - x.b;
            op_mul:  e.res.data = product[31:0];
            op_bgt:  e.res.data = ($signed(x.a) > $signed(x.b)) ? 32'd1 : 32'd0;
            op_ble:  e.res.data = ($signed(x.a) <= $signed(x.b)) ? 32'd1 : 32'd0;
            op_beq:  e.res.data = (x.a == x.b) ? 32'd1 : 32'd0;
            op_bne:  e.res.data = (x.a != x.b) ? 32'd1 : 32'd0;
            op_and:  e.res.data = x.a & x.b;
            op_or:   e.res.data = x.a | x.b;
            op_not:  e.res.data = ~x.a;
            op_satp: e.res.data = ($signed(x.a) < $signed(x.b)) ? x.a : x.b;
            op_satn: e.res.data = ($signed(x.a) > $signed(x.b)) ? x.a : x.b;
            op_ldr:  e.res.data = x.a;
            op_ldc:  e.res.data = x.b;
            op_stop: begin
                hit = 1'b0;
                e.stop = x.valid;
            end
            default: hit = 1'b0;
        endcase
        e.res.valid = x.valid && hit;
        e.res.dest = x.dest;
        e.res.zero = (e.res.data == 32'd0);
        e.res.negative = e.res.data[31];
        return e;
    endfunction

    task automatic drive_cycle(input alu_issue_t x);
        @(posedge clock);
        issue <= x;
        expect_q.push_back(expected_result(x));
    endtask

    // A slot leaves the queue once it has spent exec_latency cycles in the DUT
    task automatic check_cycle();
        expect_t e;
        logic exp_valid;
        e = '0;
        exp_valid = 1'b0;
        if (expect_q.size() > exec_latency) begin
            e = expect_q.pop_front();
            if (e.stop) begin
                model_halted = 1'b1;
            end
            exp_valid = e.res.valid && !model_halted;
        end
        assert (halted === model_halted)
            else report_value("halted", model_halted, halted);
        assert (result.valid === exp_valid)
            else report_value("result.valid", exp_valid, result.valid);
        if (exp_valid) begin
            result_count++;
            assert (result.data === e.res.data)
                else report_value("result.data", e.res.data, result.data);
            assert (result.dest === e.res.dest)
                else report_value("result.dest", e.res.dest, result.dest);
            assert (result.zero === e.res.zero)
                else report_value("result.zero", e.res.zero, result.zero);
            assert (result.negative === e.res.negative)
                else report_value("result.negative", e.res.negative, result.negative);
        end
    endtask

    // Outputs are sampled half a cycle away from the driving edge
    always @(negedge clock) begin
        if (rst_n === 1'b1) begin
            check_cycle();
        end
    end

    initial begin
        #(timeout_ns);
        $display("ERROR: watchdog expired, the run timed out at %0t", $time);
        $display("TEST FAILED");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        alu_issue_t stop_issue;
        issue = '0;
        wait (rst_n === 1'b1);
        for (int i = 0; i < num_ops; i++) begin
            drive_cycle(random_issue(1'b1));
        end
        stop_issue = random_issue(1'b1);
        stop_issue.valid = 1'b1;
        stop_issue.op = op_stop;
        drive_cycle(stop_issue);
        for (int i = 0; i < tail_cycles; i++) begin
            drive_cycle(random_issue(1'b1));
        end
        // Idle slots flush the last operations through the pipeline
        for (int i = 0; i <= exec_latency; i++) begin
            drive_cycle('0);
        end
        @(negedge clock);
        #1;
        $display("Checked %0d valid results", result_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "Errors were reported");
        end
    end

endmodule

`default_nettype wire

//--- tb.f
hw/alu_isa_pkg.sv
hw/alu_stream_pkg.sv
hw/stage_delay.sv
hw/arith_lane.sv
hw/logic_lane.sv
hw/result_merge.sv
hw/exec_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_exec_unit.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  # Packages first, then the blocks bottom up
  - hw/alu_isa_pkg.sv
  - hw/alu_stream_pkg.sv
  - hw/stage_delay.sv
  - hw/arith_lane.sv
  - hw/logic_lane.sv
  - hw/result_merge.sv
  - hw/exec_unit.sv

  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_exec_unit.sv
